/* include/l2_config.svh */
// ########################################
// Sizes shared by the L2 request path RTL
// Include wherever a depth or width is needed
// ########################################

`ifndef L2_CONFIG_SVH
`define L2_CONFIG_SVH

// Word address width of the data array
`define L2_ADDR_WIDTH 6

// Number of words in the data array, one per address
`define L2_MEM_WORDS (1 << `L2_ADDR_WIDTH)

// Width of one data word
`define L2_DATA_WIDTH 32

// Entries in each per-core request queue
`define L2_REQ_DEPTH 4

// Entries in the shared response queue
`define L2_RSP_DEPTH 4

// Free slots left when the response queue raises almost_full
// Two slots cover the request still sitting in the memory stage
`define L2_RSP_THRESHOLD 2

`endif

/* src/l2_mem_pkg.sv */
// ########################################
// Memory geometry types of the shared L2
// Import wherever addresses or words are handled
// ########################################

`include "l2_config.svh"

package l2_mem_pkg;

	// Word address into the data array
	typedef logic [`L2_ADDR_WIDTH-1:0] l2_addr_t;

	// One data word as stored in the array
	typedef logic [`L2_DATA_WIDTH-1:0] l2_data_t;

	// Identifier of the requesting core
	// Only two cores share the memory, so one bit is enough
	typedef logic l2_core_t;

endpackage

/* src/l2_txn_pkg.sv */
// ########################################
// Request and response payloads of the L2
// Carried through the request and response FIFOs
// ########################################

package l2_txn_pkg;

	import l2_mem_pkg::*;

	// A request as a core pushes it into its own queue
	// The core is implied by the queue, so it is not stored here
	typedef struct packed {
		logic     write;
		l2_addr_t addr;
		l2_data_t data;
	} l2_req_t;

	// A response as it leaves the memory stage
	// For a read the data is the value read from the array
	// For a write the data echoes the value that was written
	typedef struct packed {
		l2_core_t core;
		logic     write;
		l2_addr_t addr;
		l2_data_t data;
	} l2_rsp_t;

endpackage

/* src/sram_1r1w.sv */
// ########################################
// Storage array with one read and one write port
// Used as FIFO storage and as the L2 data array
// ########################################

`timescale 1ns/1ps

module sram_1r1w #(
	parameter type payload_t = logic [31:0],
	parameter int DEPTH = 64,
	localparam int ADDR_WIDTH = $clog2(DEPTH)
) (
	input  logic                  clk,
	input  logic [ADDR_WIDTH-1:0] rd_addr_i,
	input  logic [ADDR_WIDTH-1:0] wr_addr_i,
	input  payload_t              wr_data_i,
	input  logic                  wr_enable_i,
	output payload_t              rd_data_o
);

	// Array contents come up undefined and are only ever written by the owner
	payload_t mem [DEPTH];

	// Registered read port
	// A read and a write to the same word in one cycle return the old word
	always_ff @(posedge clk)
	begin
		if (wr_enable_i)
		begin
			mem[wr_addr_i] <= wr_data_i;
		end
		rd_data_o <= mem[rd_addr_i];
	end

endmodule

/* src/sync_fifo.sv */
// ########################################
// Circular-buffer FIFO with level flags
// Payload type and depth are set per instance
// ########################################

`timescale 1ns/1ps

module sync_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int DEPTH = 4,
	parameter int ALMOST_FULL_THRESHOLD = 1
) (
	input  logic     clk,
	input  logic     rst_n_i,
	input  logic     flush_i,
	input  logic     enqueue_i,
	input  payload_t value_i,
	input  logic     dequeue_i,
	output logic     full_o,
	output logic     almost_full_o,
	output logic     empty_o,
	output payload_t value_o
);

	localparam int ADDR_WIDTH = $clog2(DEPTH);

	// Index of the last slot, where head and tail wrap back to zero
	localparam logic [ADDR_WIDTH-1:0] LAST_SLOT = ADDR_WIDTH'(DEPTH - 1);

	// Count at which the queue holds every entry
	localparam logic [ADDR_WIDTH:0] FULL_COUNT = (ADDR_WIDTH + 1)'(DEPTH);

	// Count at which only the threshold number of slots are left free
	localparam logic [ADDR_WIDTH:0] AF_COUNT =
		(ADDR_WIDTH + 1)'(DEPTH - ALMOST_FULL_THRESHOLD);

	logic [ADDR_WIDTH-1:0] head_q;
	logic [ADDR_WIDTH-1:0] head_nxt;
	logic [ADDR_WIDTH-1:0] tail_q;
	logic [ADDR_WIDTH-1:0] tail_nxt;
	logic [ADDR_WIDTH:0]   count_q;
	logic [ADDR_WIDTH:0]   count_nxt;
	logic                  bypass_q;
	payload_t              bypass_value_q;
	payload_t              ram_value;

	// The array reads at the next head, so the entry at the head is
	// always presented right after the edge that moved the head
	sram_1r1w #(
		.payload_t (payload_t),
		.DEPTH     (DEPTH)
	) i_storage (
		.clk         (clk),
		.rd_addr_i   (head_nxt),
		.wr_addr_i   (tail_q),
		.wr_data_i   (value_i),
		.wr_enable_i (enqueue_i),
		.rd_data_o   (ram_value)
	);

	// Next pointer and count values
	always_comb
	begin
		head_nxt = head_q;
		tail_nxt = tail_q;
		count_nxt = count_q;
		if (flush_i)
		begin
			// Flush drops every entry and rewinds both pointers
			head_nxt = '0;
			tail_nxt = '0;
			count_nxt = '0;
		end
		else
		begin
			if (enqueue_i)
			begin
				tail_nxt = (tail_q == LAST_SLOT) ? '0 : tail_q + 1'b1;
			end
			if (dequeue_i)
			begin
				head_nxt = (head_q == LAST_SLOT) ? '0 : head_q + 1'b1;
			end
			// Count only moves when exactly one side is active
			if (enqueue_i && !dequeue_i)
			begin
				count_nxt = count_q + 1'b1;
			end
			else if (dequeue_i && !enqueue_i)
			begin
				count_nxt = count_q - 1'b1;
			end
		end
	end

	// Pointers, count and level flags
	// The flags are registered from the next count so they line up with it
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
			full_o <= 1'b0;
			almost_full_o <= 1'b0;
			empty_o <= 1'b1;
			bypass_q <= 1'b0;
		end
		else
		begin
			head_q <= head_nxt;
			tail_q <= tail_nxt;
			count_q <= count_nxt;
			full_o <= (count_nxt == FULL_COUNT);
			almost_full_o <= (count_nxt >= AF_COUNT);
			empty_o <= (count_nxt == '0);
			// Slot being written is the one the array reads at this edge,
			// so the array returns the old word and the new one is taken here
			bypass_q <= !flush_i && enqueue_i && (tail_q == head_nxt);
		end
	end

	// Copy of the word being written, for the bypass case above
	always_ff @(posedge clk)
	begin
		if (enqueue_i)
		begin
			bypass_value_q <= value_i;
		end
	end

	assign value_o = bypass_q ? bypass_value_q : ram_value;

endmodule

/* src/l2_arbiter.sv */
// ########################################
// Round-robin arbiter over the two request queues
// Stalls while the response queue is almost full
// ########################################

`timescale 1ns/1ps

module l2_arbiter (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 flush_i,
	input  logic [1:0]           req_empty_i,
	input  logic                 rsp_almost_full_i,
	output logic [1:0]           req_dequeue_o,
	output logic                 grant_valid_o,
	output l2_mem_pkg::l2_core_t grant_core_o
);

	import l2_mem_pkg::*;

	// Core that won the most recent grant
	l2_core_t last_core_q;
	logic [1:0] pending;

	// Grant decision is combinational, in the same cycle as the queue heads
	always_comb
	begin
		pending = ~req_empty_i;
		// No grant during flush, and none while a response could not be taken
		grant_valid_o = !flush_i && !rsp_almost_full_i && (pending != 2'b00);
		if (pending == 2'b11)
		begin
			// Both cores waiting, so the one not served last goes first
			grant_core_o = ~last_core_q;
		end
		else
		begin
			// A single waiting core is picked directly
			grant_core_o = l2_core_t'(pending[1]);
		end
		// The granted queue pops its head at the grant edge
		req_dequeue_o[0] = grant_valid_o && (grant_core_o == 1'b0);
		req_dequeue_o[1] = grant_valid_o && (grant_core_o == 1'b1);
	end

	// Priority register
	// Starts pointing at core 1 so that core 0 wins the first tie
	always_ff @(posedge clk)
	begin
		if (!rst_n_i || flush_i)
		begin
			last_core_q <= 1'b1;
		end
		else if (grant_valid_o)
		begin
			last_core_q <= grant_core_o;
		end
	end

endmodule

/* src/l2_memory_stage.sv */
// ########################################
// Memory stage of the L2 request path
// One granted request per cycle, response a cycle later
// ########################################

`timescale 1ns/1ps

`include "l2_config.svh"

module l2_memory_stage (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 flush_i,
	input  logic                 grant_valid_i,
	input  l2_mem_pkg::l2_core_t grant_core_i,
	input  l2_txn_pkg::l2_req_t  req_i,
	output logic                 rsp_valid_o,
	output l2_txn_pkg::l2_rsp_t  rsp_o
);

	import l2_mem_pkg::*;

	// Stage register, one request in flight
	logic     stage_valid_q;
	l2_core_t stage_core_q;
	logic     stage_write_q;
	l2_addr_t stage_addr_q;
	l2_data_t stage_data_q;

	// Forwarding of a write that commits while the next read samples the array
	logic     fwd_hit_q;
	l2_data_t fwd_data_q;

	logic     array_wr_enable;
	l2_data_t array_rd_data;

	// Writes commit from the stage register, one cycle after their grant
	assign array_wr_enable = stage_valid_q && stage_write_q;

	// Reads address the array straight from the granted request
	sram_1r1w #(
		.payload_t (l2_data_t),
		.DEPTH     (`L2_MEM_WORDS)
	) i_data_array (
		.clk         (clk),
		.rd_addr_i   (req_i.addr),
		.wr_addr_i   (stage_addr_q),
		.wr_data_i   (stage_data_q),
		.wr_enable_i (array_wr_enable),
		.rd_data_o   (array_rd_data)
	);

	// Control part of the stage
	always_ff @(posedge clk)
	begin
		if (!rst_n_i || flush_i)
		begin
			stage_valid_q <= 1'b0;
			fwd_hit_q <= 1'b0;
		end
		else
		begin
			stage_valid_q <= grant_valid_i;
			// A read to the word being written at this edge sees stale data
			fwd_hit_q <= grant_valid_i && !req_i.write && array_wr_enable
				&& (stage_addr_q == req_i.addr);
		end
	end

	// Payload part of the stage, loaded only on a grant
	always_ff @(posedge clk)
	begin
		if (grant_valid_i)
		begin
			stage_core_q <= grant_core_i;
			stage_write_q <= req_i.write;
			stage_addr_q <= req_i.addr;
			stage_data_q <= req_i.data;
		end
		if (array_wr_enable)
		begin
			fwd_data_q <= stage_data_q;
		end
	end

	// Response toward the response queue
	always_comb
	begin
		rsp_valid_o = stage_valid_q;
		rsp_o.core = stage_core_q;
		rsp_o.write = stage_write_q;
		rsp_o.addr = stage_addr_q;
		if (stage_write_q)
		begin
			// Writes echo their own data
			rsp_o.data = stage_data_q;
		end
		else if (fwd_hit_q)
		begin
			rsp_o.data = fwd_data_q;
		end
		else
		begin
			rsp_o.data = array_rd_data;
		end
	end

endmodule

/* src/l2_request_path.sv */
// ########################################
// Top of the shared L2 request path
// Two request queues, arbiter, memory, response queue
// ########################################

`timescale 1ns/1ps

`include "l2_config.svh"

module l2_request_path (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 flush_i,
	input  logic                 core0_req_enqueue_i,
	input  logic                 core0_req_write_i,
	input  l2_mem_pkg::l2_addr_t core0_req_addr_i,
	input  l2_mem_pkg::l2_data_t core0_req_data_i,
	input  logic                 core1_req_enqueue_i,
	input  logic                 core1_req_write_i,
	input  l2_mem_pkg::l2_addr_t core1_req_addr_i,
	input  l2_mem_pkg::l2_data_t core1_req_data_i,
	output logic                 core0_req_full_o,
	output logic                 core1_req_full_o,
	input  logic                 rsp_dequeue_i,
	output logic                 rsp_empty_o,
	output l2_mem_pkg::l2_core_t rsp_core_o,
	output logic                 rsp_write_o,
	output l2_mem_pkg::l2_addr_t rsp_addr_o,
	output l2_mem_pkg::l2_data_t rsp_data_o
);

	import l2_mem_pkg::*;
	import l2_txn_pkg::*;

	// Packed requests entering and leaving the per-core queues
	l2_req_t core0_req;
	l2_req_t core1_req;
	l2_req_t core0_head;
	l2_req_t core1_head;
	l2_req_t granted_req;
	logic    core0_empty;
	logic    core1_empty;

	// Arbiter outputs
	logic [1:0] req_dequeue;
	logic       grant_valid;
	l2_core_t   grant_core;

	// Response side
	logic    rsp_valid;
	l2_rsp_t stage_rsp;
	l2_rsp_t rsp_head;
	logic    rsp_almost_full;

	assign core0_req = '{write: core0_req_write_i, addr: core0_req_addr_i,
		data: core0_req_data_i};
	assign core1_req = '{write: core1_req_write_i, addr: core1_req_addr_i,
		data: core1_req_data_i};

	// Request queue of core 0
	sync_fifo #(
		.payload_t (l2_req_t),
		.DEPTH     (`L2_REQ_DEPTH)
	) i_core0_req_fifo (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.flush_i       (flush_i),
		.enqueue_i     (core0_req_enqueue_i),
		.value_i       (core0_req),
		.dequeue_i     (req_dequeue[0]),
		.full_o        (core0_req_full_o),
		.almost_full_o (),
		.empty_o       (core0_empty),
		.value_o       (core0_head)
	);

	// Request queue of core 1
	sync_fifo #(
		.payload_t (l2_req_t),
		.DEPTH     (`L2_REQ_DEPTH)
	) i_core1_req_fifo (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.flush_i       (flush_i),
		.enqueue_i     (core1_req_enqueue_i),
		.value_i       (core1_req),
		.dequeue_i     (req_dequeue[1]),
		.full_o        (core1_req_full_o),
		.almost_full_o (),
		.empty_o       (core1_empty),
		.value_o       (core1_head)
	);

	l2_arbiter i_arbiter (
		.clk               (clk),
		.rst_n_i           (rst_n_i),
		.flush_i           (flush_i),
		.req_empty_i       ({core1_empty, core0_empty}),
		.rsp_almost_full_i (rsp_almost_full),
		.req_dequeue_o     (req_dequeue),
		.grant_valid_o     (grant_valid),
		.grant_core_o      (grant_core)
	);

	// Head of the granted queue goes to the memory stage in the grant cycle
	assign granted_req = grant_core ? core1_head : core0_head;

	l2_memory_stage i_memory_stage (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.flush_i       (flush_i),
		.grant_valid_i (grant_valid),
		.grant_core_i  (grant_core),
		.req_i         (granted_req),
		.rsp_valid_o   (rsp_valid),
		.rsp_o         (stage_rsp)
	);

	// Response queue, its almost_full holds back the arbiter
	// It never fills since the threshold leaves room for the request in flight
	sync_fifo #(
		.payload_t             (l2_rsp_t),
		.DEPTH                 (`L2_RSP_DEPTH),
		.ALMOST_FULL_THRESHOLD (`L2_RSP_THRESHOLD)
	) i_rsp_fifo (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.flush_i       (flush_i),
		.enqueue_i     (rsp_valid),
		.value_i       (stage_rsp),
		.dequeue_i     (rsp_dequeue_i),
		.full_o        (),
		.almost_full_o (rsp_almost_full),
		.empty_o       (rsp_empty_o),
		.value_o       (rsp_head)
	);

	assign rsp_core_o = rsp_head.core;
	assign rsp_write_o = rsp_head.write;
	assign rsp_addr_o = rsp_head.addr;
	assign rsp_data_o = rsp_head.data;

endmodule

/* tests/l2_checker.sv */
// ########################################
// Scoreboard for the L2 request path testbench
// Watches DUT ports and compares every dequeued response
// ########################################

`timescale 1ns/1ps

`include "l2_config.svh"

module l2_checker (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 flush_i,
	input  logic                 core0_req_enqueue_i,
	input  logic                 core0_req_write_i,
	input  l2_mem_pkg::l2_addr_t core0_req_addr_i,
	input  l2_mem_pkg::l2_data_t core0_req_data_i,
	input  logic                 core0_req_full_i,
	input  logic                 core1_req_enqueue_i,
	input  logic                 core1_req_write_i,
	input  l2_mem_pkg::l2_addr_t core1_req_addr_i,
	input  l2_mem_pkg::l2_data_t core1_req_data_i,
	input  logic                 core1_req_full_i,
	input  logic                 rsp_dequeue_i,
	input  logic                 rsp_empty_i,
	input  l2_mem_pkg::l2_core_t rsp_core_i,
	input  logic                 rsp_write_i,
	input  l2_mem_pkg::l2_addr_t rsp_addr_i,
	input  l2_mem_pkg::l2_data_t rsp_data_i,
	input  logic                 alt_check_i,
	output int                   error_count_o,
	output int                   outstanding_o
);

	import l2_mem_pkg::*;
	import l2_txn_pkg::*;

	// Accepted requests of each core, oldest first
	l2_req_t expect_q0[$];
	l2_req_t expect_q1[$];

	// Shadow of the data array, with a flag for words written at least once
	l2_data_t shadow_mem [`L2_MEM_WORDS];
	logic     shadow_known [`L2_MEM_WORDS];

	logic     alt_have_prev;
	l2_core_t alt_prev_core;

	initial
	begin
		error_count_o = 0;
		outstanding_o = 0;
		alt_have_prev = 1'b0;
		for (int i = 0; i < `L2_MEM_WORDS; i++)
		begin
			shadow_known[i] = 1'b0;
		end
	end

	// Data the response must carry
	// A write echoes its own data, a read returns the last write to its word
	function automatic l2_data_t reference_data(input l2_req_t req);
		if (req.write)
		begin
			return req.data;
		end
		return shadow_mem[req.addr];
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
			error_count_o++;
		end
	endtask

	task automatic report_problem(input string text);
		$display("%s at %0t", text, $time);
		error_count_o++;
	endtask

	// Pops the oldest request of the core owning the response address
	task automatic check_response();
		l2_req_t  req;
		l2_core_t owner;
		bit       have_req;
		// Each core owns one half of the address space
		owner = rsp_addr_i[`L2_ADDR_WIDTH-1];
		have_req = owner ? (expect_q1.size() != 0) : (expect_q0.size() != 0);
		if (!have_req)
		begin
			report_problem("A response came out for an address with no pending request");
		end
		else
		begin
			if (owner)
			begin
				req = expect_q1.pop_front();
			end
			else
			begin
				req = expect_q0.pop_front();
			end
			compare_value("rsp_core_o", rsp_core_i, owner);
			compare_value("rsp_write_o", rsp_write_i, req.write);
			compare_value("rsp_addr_o", rsp_addr_i, req.addr);
			if (req.write || shadow_known[req.addr])
			begin
				compare_value("rsp_data_o", rsp_data_i, reference_data(req));
			end
			if (req.write)
			begin
				shadow_mem[req.addr] = req.data;
				shadow_known[req.addr] = 1'b1;
			end
		end
		// Consecutive responses must come from different cores when enabled
		if (alt_check_i && alt_have_prev && rsp_core_i == alt_prev_core)
		begin
			report_problem("Two responses in a row came from the same core");
		end
		alt_have_prev = alt_check_i;
		alt_prev_core = rsp_core_i;
	endtask

	// Inputs and outputs are read here before the edge updates them
	always @(posedge clk)
	begin
		if (!rst_n_i || flush_i)
		begin
			expect_q0.delete();
			expect_q1.delete();
			alt_have_prev = 1'b0;
		end
		else
		begin
			if (core0_req_enqueue_i && core0_req_full_i)
				report_problem("Core 0 enqueued into a full request queue");
			else if (core0_req_enqueue_i)
				expect_q0.push_back({core0_req_write_i, core0_req_addr_i, core0_req_data_i});
			if (core1_req_enqueue_i && core1_req_full_i)
				report_problem("Core 1 enqueued into a full request queue");
			else if (core1_req_enqueue_i)
				expect_q1.push_back({core1_req_write_i, core1_req_addr_i, core1_req_data_i});
			if (rsp_dequeue_i && rsp_empty_i)
				report_problem("The response queue was dequeued while empty");
			else if (rsp_dequeue_i)
				check_response();
		end
		outstanding_o = expect_q0.size() + expect_q1.size();
	end

endmodule

/* tests/tb_l2_request_path.sv */
// ########################################
// Testbench top for the L2 request path
// Random and directed traffic, checked by l2_checker
// ########################################

`timescale 1ns/1ps

module tb_l2_request_path;

	import l2_mem_pkg::*;

	logic clk = 1'b0;
	logic rst_n_i, flush_i, rsp_dequeue_i, alt_check;
	logic core0_req_enqueue_i, core0_req_write_i, core1_req_enqueue_i, core1_req_write_i;
	l2_addr_t core0_req_addr_i, core1_req_addr_i;
	l2_data_t core0_req_data_i, core1_req_data_i;
	logic core0_req_full_o, core1_req_full_o, rsp_empty_o, rsp_write_o;
	l2_core_t rsp_core_o;
	l2_addr_t rsp_addr_o;
	l2_data_t rsp_data_o;
	int chk_errors, outstanding, tb_errors = 0;
	logic [31:0] lcg_state = 32'd14;

	always #10 clk = ~clk;

	l2_request_path i_l2_request_path (.*);

	l2_checker i_checker (
		.clk                 (clk),
		.rst_n_i             (rst_n_i),
		.flush_i             (flush_i),
		.core0_req_enqueue_i (core0_req_enqueue_i),
		.core0_req_write_i   (core0_req_write_i),
		.core0_req_addr_i    (core0_req_addr_i),
		.core0_req_data_i    (core0_req_data_i),
		.core0_req_full_i    (core0_req_full_o),
		.core1_req_enqueue_i (core1_req_enqueue_i),
		.core1_req_write_i   (core1_req_write_i),
		.core1_req_addr_i    (core1_req_addr_i),
		.core1_req_data_i    (core1_req_data_i),
		.core1_req_full_i    (core1_req_full_o),
		.rsp_dequeue_i       (rsp_dequeue_i),
		.rsp_empty_i         (rsp_empty_o),
		.rsp_core_i          (rsp_core_o),
		.rsp_write_i         (rsp_write_o),
		.rsp_addr_i          (rsp_addr_o),
		.rsp_data_i          (rsp_data_o),
		.alt_check_i         (alt_check),
		.error_count_o       (chk_errors),
		.outstanding_o       (outstanding)
	);

	// Linear congruential generator seeded with 14
	// Its upper bits carry the most randomness
	function automatic logic [31:0] draw_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {lcg_state[30:15], lcg_state[15:0] ^ lcg_state[31:16]};
	endfunction

	task automatic expect_level(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
			tb_errors++;
		end
	endtask

	// Strobes are driven at most every other cycle, so the levels read
	// at the falling edge still hold when the strobe is sampled
	task automatic traffic(input int cycles, input bit enq_on, input bit busy,
		input bit drain, input bit reads_only, input bit stop_full);
		bit e0, e1, d, p0, p1, pd, seen_rsp, done;
		logic [31:0] r, r2;
		p0 = 0;
		p1 = 0;
		pd = 0;
		seen_rsp = 0;
		done = 0;
		for (int i = 0; i < cycles && !done; i++)
		begin
			@(negedge clk);
			if (stop_full)
			begin
				if (seen_rsp && rsp_empty_o)
				begin
					$display("Response queue went empty while dequeue was held low");
					tb_errors++;
				end
				seen_rsp = seen_rsp || !rsp_empty_o;
				done = core0_req_full_o && core1_req_full_o;
			end
			r = draw_random();
			r2 = draw_random();
			e0 = enq_on && !done && !p0 && !core0_req_full_o && (busy || r[0]);
			e1 = enq_on && !done && !p1 && !core1_req_full_o && (busy || r[1]);
			d = drain && !pd && !rsp_empty_o && (busy || r[2]);
			@(posedge clk);
			core0_req_enqueue_i <= e0;
			core0_req_write_i <= !reads_only && r[3];
			core0_req_addr_i <= {2'b00, r[7:4]};
			core0_req_data_i <= r2;
			core1_req_enqueue_i <= e1;
			core1_req_write_i <= !reads_only && r[12];
			core1_req_addr_i <= {2'b10, r[11:8]};
			core1_req_data_i <= ~r2;
			rsp_dequeue_i <= d;
			p0 = e0;
			p1 = e1;
			pd = d;
		end
		if (stop_full && !done)
		begin
			$display("Both request queues did not become full in time");
			tb_errors++;
		end
		@(posedge clk);
		core0_req_enqueue_i <= 1'b0;
		core1_req_enqueue_i <= 1'b0;
		rsp_dequeue_i <= 1'b0;
	endtask

	// Drains responses until nothing is outstanding
	task automatic wait_drained();
		int waited;
		for (waited = 0; waited < 400; waited++)
		begin
			@(negedge clk);
			if (outstanding == 0 && rsp_empty_o)
				break;
			traffic(1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
		end
		if (waited == 400)
		begin
			$display("Responses were still outstanding after the drain timeout");
			tb_errors++;
		end
	endtask

	// Back-to-back write and read of one word, granted in consecutive cycles
	task automatic write_then_read(input bit core, input l2_addr_t addr, input l2_data_t data);
		@(posedge clk);
		core0_req_enqueue_i <= !core;
		core1_req_enqueue_i <= core;
		core0_req_write_i <= 1'b1;
		core1_req_write_i <= 1'b1;
		core0_req_addr_i <= addr;
		core1_req_addr_i <= addr;
		core0_req_data_i <= data;
		core1_req_data_i <= data;
		@(posedge clk);
		core0_req_write_i <= 1'b0;
		core1_req_write_i <= 1'b0;
		@(posedge clk);
		core0_req_enqueue_i <= 1'b0;
		core1_req_enqueue_i <= 1'b0;
		wait_drained();
	endtask

	initial
	begin
		rst_n_i = 1'b0;
		flush_i = 1'b0;
		rsp_dequeue_i = 1'b0;
		alt_check = 1'b0;
		core0_req_enqueue_i = 1'b0;
		core0_req_write_i = 1'b0;
		core0_req_addr_i = '0;
		core0_req_data_i = '0;
		core1_req_enqueue_i = 1'b0;
		core1_req_write_i = 1'b0;
		core1_req_addr_i = '0;
		core1_req_data_i = '0;
		repeat (16) @(posedge clk);
		rst_n_i <= 1'b1;
		@(negedge clk);
		expect_level("rsp_empty_o", rsp_empty_o, 1'b1);
		expect_level("core0_req_full_o", core0_req_full_o, 1'b0);
		expect_level("core1_req_full_o", core1_req_full_o, 1'b0);
		// Forwarding, then mixed reads and writes over a small address set
		write_then_read(1'b0, 6'h05, 32'hcafe_0005);
		write_then_read(1'b1, 6'h25, 32'h1234_5678);
		traffic(300, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
		wait_drained();
		// Back-pressure until both cores are full, then fair draining
		traffic(200, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
		traffic(20, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
		alt_check <= 1'b1;
		traffic(200, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
		alt_check <= 1'b0;
		wait_drained();
		// Pending reads fill both request queues and are thrown away by the flush
		traffic(200, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1);
		@(posedge clk);
		flush_i <= 1'b1;
		@(posedge clk);
		flush_i <= 1'b0;
		@(negedge clk);
		expect_level("rsp_empty_o", rsp_empty_o, 1'b1);
		expect_level("core0_req_full_o", core0_req_full_o, 1'b0);
		expect_level("core1_req_full_o", core1_req_full_o, 1'b0);
		traffic(200, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
		wait_drained();
		$display("Errors: checker %0d, testbench %0d", chk_errors, tb_errors);
		if (chk_errors == 0 && tb_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* all.f */
+incdir+include
src/l2_mem_pkg.sv
src/l2_txn_pkg.sv
src/sram_1r1w.sv
src/sync_fifo.sv
src/l2_arbiter.sv
src/l2_memory_stage.sv
src/l2_request_path.sv
tests/l2_checker.sv
tests/tb_l2_request_path.sv
